//--- include/route_consts.svh
`ifndef ROUTE_CONSTS_SVH
`define ROUTE_CONSTS_SVH

// mesh size, routers along each axis
`define MESH_NX 4
`define MESH_NY 4

// address widths, wide enough for MESH_NX and MESH_NY
`define MESH_XW 2
`define MESH_YW 2

// router ports in a 2d mesh: local plus four neighbours
`define MESH_PORTS 5

// encoded port {x, y, a, b}
//   x  1 east, 0 west
//   y  1 north, 0 south
//   ab 00 local, 10 x direction, 01 y direction
`define PORT_CODE_W 4

`endif

//--- design/route_pkg.sv
`include "route_consts.svh"

package route_pkg;

    // bit positions inside a one-hot port vector
    typedef enum logic [2:0] {
        LOCAL = 3'd0,   // attached node
        EAST  = 3'd1,   // x + 1
        NORTH = 3'd2,   // y - 1
        WEST  = 3'd3,   // x - 1
        SOUTH = 3'd4    // y + 1
    } mesh_port_e;

    // router coordinates
    typedef logic [`MESH_XW-1:0] x_addr_t;  // column
    typedef logic [`MESH_YW-1:0] y_addr_t;  // row

    // Encoded output port as it travels in the packet header.
    // Only one of the ab bits may be set under deterministic routing,
    // the x and y bits then pick the side along that axis.
    typedef logic [`PORT_CODE_W-1:0] port_code_t;

    // one bit per router port, indexed by mesh_port_e
    typedef logic [`MESH_PORTS-1:0] port_onehot_t;

endpackage

//--- design/dest_port_decoder.sv
`timescale 1ns/10ps

module dest_port_decoder (
    input  logic                  valid,
    input  route_pkg::port_code_t port_code,
    output route_pkg::port_onehot_t port_onehot
);
    import route_pkg::*;

    logic       x_dir;  // 1 east, 0 west
    logic       y_dir;  // 1 north, 0 south
    logic [1:0] ab;     // axis select

    assign {x_dir, y_dir, ab} = port_code;

    always_comb begin
        port_onehot = '0;
        case (ab)
            2'b10: begin
                if (x_dir) begin
                    port_onehot[EAST] = 1'b1;
                end else begin
                    port_onehot[WEST] = 1'b1;
                end
            end
            2'b01: begin
                if (y_dir) begin
                    port_onehot[NORTH] = 1'b1;
                end else begin
                    port_onehot[SOUTH] = 1'b1;
                end
            end
            2'b00:   port_onehot[LOCAL] = 1'b1;
            default: port_onehot = '0;  // both axes, not a legal xy code
        endcase
    end

    // the header register upstream must never carry a two-axis code
    always_comb begin
        if (valid) begin
            assert (ab != 2'b11)
                else $error("dest_port_decoder: illegal port code %b", port_code);
        end
    end

endmodule

//--- design/next_router_addr_predictor.sv
`timescale 1ns/10ps
`include "route_consts.svh"

module next_router_addr_predictor #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  route_pkg::port_onehot_t port_onehot,
    output route_pkg::x_addr_t      next_x,
    output route_pkg::y_addr_t      next_y
);
    import route_pkg::*;

    // own position and mesh edges
    localparam x_addr_t CUR_X  = x_addr_t'(ROUTER_X);
    localparam y_addr_t CUR_Y  = y_addr_t'(ROUTER_Y);
    localparam x_addr_t LAST_X = x_addr_t'(`MESH_NX - 1);
    localparam y_addr_t LAST_Y = y_addr_t'(`MESH_NY - 1);

    always_comb begin
        next_x = CUR_X;  // local or no port keeps the address
        next_y = CUR_Y;
        if (port_onehot[EAST]) begin
            if (CUR_X == LAST_X) begin
                next_x = '0;
            end else begin
                next_x = x_addr_t'(CUR_X + 1'b1);
            end
        end else if (port_onehot[NORTH]) begin
            if (CUR_Y == '0) begin  // north moves toward row 0
                next_y = LAST_Y;
            end else begin
                next_y = y_addr_t'(CUR_Y - 1'b1);
            end
        end else if (port_onehot[WEST]) begin
            if (CUR_X == '0) begin
                next_x = LAST_X;
            end else begin
                next_x = x_addr_t'(CUR_X - 1'b1);
            end
        end else if (port_onehot[SOUTH]) begin
            if (CUR_Y == LAST_Y) begin
                next_y = '0;
            end else begin
                next_y = y_addr_t'(CUR_Y + 1'b1);
            end
        end
    end

    // the decoder feeding this block must hand over a single port at most
    always_comb begin
        assert ($onehot0(port_onehot))
            else $error("next_router_addr_predictor: port vector %b not one-hot",
                        port_onehot);
    end

endmodule

//--- design/xy_mesh_routing.sv
`timescale 1ns/10ps

module xy_mesh_routing (
    input  route_pkg::x_addr_t    current_x,
    input  route_pkg::y_addr_t    current_y,
    input  route_pkg::x_addr_t    dest_x,
    input  route_pkg::y_addr_t    dest_y,
    output route_pkg::port_code_t destport
);
    import route_pkg::*;

    mesh_port_e route_dir;  // chosen output port

    // x first, then y
    always_comb begin
        route_dir = LOCAL;
        if (dest_x > current_x) begin
            route_dir = EAST;
        end else if (dest_x < current_x) begin
            route_dir = WEST;
        end else if (dest_y < current_y) begin
            route_dir = NORTH;  // lower row index lies north
        end else if (dest_y > current_y) begin
            route_dir = SOUTH;
        end
    end

    logic       x_dir;
    logic       y_dir;
    logic [1:0] ab;

    // pack the direction as {x, y, a, b}, unused side bits stay zero
    always_comb begin
        x_dir = 1'b0;
        y_dir = 1'b0;
        ab    = 2'b00;
        case (route_dir)
            EAST: begin
                x_dir = 1'b1;
                ab    = 2'b10;
            end
            WEST: begin
                ab    = 2'b10;
            end
            NORTH: begin
                y_dir = 1'b1;
                ab    = 2'b01;
            end
            SOUTH: begin
                ab    = 2'b01;
            end
            default: begin
                ab    = 2'b00;  // eject at this router
            end
        endcase
    end

    assign destport = {x_dir, y_dir, ab};

endmodule

//--- design/mesh_look_ahead_routing.sv
`timescale 1ns/10ps
`include "route_consts.svh"

module mesh_look_ahead_routing #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  route_pkg::x_addr_t    dest_x,
    input  route_pkg::y_addr_t    dest_y,
    input  route_pkg::port_code_t destport,
    output logic                  out_valid,
    output route_pkg::port_code_t lk_destport
);
    import route_pkg::*;

    logic         valid_q;      // header held in the register
    x_addr_t      dest_x_q;
    y_addr_t      dest_y_q;
    port_code_t   destport_q;   // output port at this router

    port_onehot_t port_onehot;
    x_addr_t      next_x;       // neighbour the packet moves to
    y_addr_t      next_y;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // header payload, held across idle cycles
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dest_x_q   <= dest_x;
            dest_y_q   <= dest_y;
            destport_q <= destport;
        end
    end

    assign out_valid = valid_q;

    dest_port_decoder dest_port_decoder_inst (
        .valid       (valid_q),
        .port_code   (destport_q),
        .port_onehot (port_onehot)
    );

    next_router_addr_predictor #(
        .ROUTER_X (ROUTER_X),
        .ROUTER_Y (ROUTER_Y)
    ) next_router_addr_predictor_inst (
        .port_onehot (port_onehot),
        .next_x      (next_x),
        .next_y      (next_y)
    );

    // xy decision as taken one hop ahead
    xy_mesh_routing xy_mesh_routing_inst (
        .current_x (next_x),
        .current_y (next_y),
        .dest_x    (dest_x_q),
        .dest_y    (dest_y_q),
        .destport  (lk_destport)
    );

    // no header accepted yet in the cycle after reset release
    property p_idle_after_reset;
        @(posedge clk) $rose(arst_n) |-> !out_valid;
    endproperty

    a_idle_after_reset: assert property (p_idle_after_reset)
        else $error("mesh_look_ahead_routing: out_valid high after reset release");

    // destinations come from the same mesh
    property p_dest_in_mesh;
        @(posedge clk) disable iff (!arst_n)
            in_valid |-> ((int'(dest_x) < `MESH_NX) && (int'(dest_y) < `MESH_NY));
    endproperty

    a_dest_in_mesh: assert property (p_dest_in_mesh)
        else $error("mesh_look_ahead_routing: destination (%0d,%0d) outside mesh",
                    dest_x, dest_y);

endmodule

//--- testbench/tb_mesh_look_ahead_routing.sv
`timescale 1ns/10ps
`include "route_consts.svh"

module tb_mesh_look_ahead_routing;
    import route_pkg::*;

    localparam int ROUTER_X = 1;
    localparam int ROUTER_Y = 2;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       in_valid;
    x_addr_t    dest_x;
    y_addr_t    dest_y;
    port_code_t destport;
    logic       out_valid;
    port_code_t lk_destport;

    port_code_t exp_q[$];         // expected lk_destport, oldest first
    logic       model_valid;      // header the DUT should hold now
    port_code_t model_port;

    always #5 clk = ~clk;

    mesh_look_ahead_routing #(
        .ROUTER_X (ROUTER_X),
        .ROUTER_Y (ROUTER_Y)
    ) mesh_look_ahead_routing_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .dest_x      (dest_x),
        .dest_y      (dest_y),
        .destport    (destport),
        .out_valid   (out_valid),
        .lk_destport (lk_destport)
    );

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_value_error(input string signal_name, input string expected,
                                      input string actual);
        stop_run($sformatf("Error at time %0t: %s expected %s, actual %s",
                           $time, signal_name, expected, actual));
    endtask

    // xy rule: x first, lower row index is north
    function automatic port_code_t xy_port_code(input int cx, input int cy,
                                                input int dx, input int dy);
        port_code_t code;
        if (dx > cx) begin
            code = 4'b1010;
        end else if (dx < cx) begin
            code = 4'b0010;
        end else if (dy < cy) begin
            code = 4'b0101;
        end else if (dy > cy) begin
            code = 4'b0001;
        end else begin
            code = 4'b0000;
        end
        return code;
    endfunction

    // column reached through an encoded port, wraps at the edges
    function automatic int step_x(input port_code_t code, input int cx);
        if (code[1:0] != 2'b10) begin
            return cx;
        end else if (code[3]) begin
            return (cx + 1) % `MESH_NX;
        end else begin
            return (cx + `MESH_NX - 1) % `MESH_NX;
        end
    endfunction

    // row reached through an encoded port, north is row - 1
    function automatic int step_y(input port_code_t code, input int cy);
        if (code[1:0] != 2'b01) begin
            return cy;
        end else if (code[2]) begin
            return (cy + `MESH_NY - 1) % `MESH_NY;
        end else begin
            return (cy + 1) % `MESH_NY;
        end
    endfunction

    function automatic port_code_t lookahead_code(input int dx, input int dy);
        port_code_t here;
        here = xy_port_code(ROUTER_X, ROUTER_Y, dx, dy);
        return xy_port_code(step_x(here, ROUTER_X), step_y(here, ROUTER_Y), dx, dy);
    endfunction

    // one header, sampled at the next rising edge
    task automatic drive_header(input int dx, input int dy);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        dest_x   = x_addr_t'(dx);
        dest_y   = y_addr_t'(dy);
        destport = xy_port_code(ROUTER_X, ROUTER_Y, dx, dy);
        exp_q.push_back(lookahead_code(dx, dy));
    endtask

    // bus content is junk on purpose, the register must ignore it
    task automatic insert_idle_cycle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        dest_x   = x_addr_t'($urandom_range(`MESH_NX - 1, 0));
        dest_y   = y_addr_t'($urandom_range(`MESH_NY - 1, 0));
        destport = port_code_t'($urandom_range(15, 0));
    endtask

    task automatic send_random_burst(input int count);
        for (int i = 0; i < count; i++) begin
            drive_header($urandom_range(`MESH_NX - 1, 0), $urandom_range(`MESH_NY - 1, 0));
        end
    endtask

    task automatic send_gapped_traffic(input int count);
        for (int i = 0; i < count; i++) begin
            if ($urandom_range(1, 0) == 1) begin
                drive_header($urandom_range(`MESH_NX - 1, 0),
                             $urandom_range(`MESH_NY - 1, 0));
            end else begin
                insert_idle_cycle();
            end
        end
    endtask

    task automatic wait_for_drain(input int max_cycles);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || model_valid) begin
            if (waited >= max_cycles) begin
                stop_run("timeout while waiting for the last headers to leave the DUT");
            end else begin
                insert_idle_cycle();
                waited++;
            end
        end
    endtask

    // reference pipeline stage, one cycle behind the inputs
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            model_valid <= 1'b0;
            model_port  <= '0;
        end else begin
            model_valid <= in_valid;
            if (in_valid) begin
                model_port <= exp_q.pop_front();
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else report_value_error("out_valid", "0", $sformatf("%b", $sampled(out_valid)));

    a_out_valid: assert property (
        @(posedge clk) disable iff (!arst_n) out_valid == model_valid
    ) else report_value_error("out_valid", $sformatf("%b", $sampled(model_valid)),
                              $sformatf("%b", $sampled(out_valid)));

    a_header_latency: assert property (
        @(posedge clk) disable iff (!arst_n) in_valid |=> out_valid
    ) else report_value_error("out_valid", "1", $sformatf("%b", $sampled(out_valid)));

    // bubble in, bubble out one cycle later
    a_idle_gap: assert property (
        @(posedge clk) disable iff (!arst_n) !in_valid |=> !out_valid
    ) else report_value_error("out_valid", "0", $sformatf("%b", $sampled(out_valid)));

    a_lk_destport: assert property (
        @(posedge clk) disable iff (!arst_n) model_valid |-> (lk_destport == model_port)
    ) else report_value_error("lk_destport", $sformatf("%b", $sampled(model_port)),
                              $sformatf("%b", $sampled(lk_destport)));

    initial begin
        arst_n   = 1'b1;
        in_valid = 1'b0;
        dest_x   = '0;
        dest_y   = '0;
        destport = '0;
        void'($urandom(32'h22af_7e2b));

        #1;
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // quiet after reset until the first header
        repeat (3) insert_idle_cycle();

        drive_header(ROUTER_X, ROUTER_Y);  // local here, local ahead

        // one hop each way, next router is the destination
        drive_header(ROUTER_X + 1, ROUTER_Y);
        drive_header(ROUTER_X - 1, ROUTER_Y);
        drive_header(ROUTER_X, ROUTER_Y - 1);
        drive_header(ROUTER_X, ROUTER_Y + 1);

        // one hop each way, route continues past the neighbour
        drive_header(3, 0);
        drive_header(0, 3);
        drive_header(ROUTER_X, 0);
        drive_header(2, 1);

        send_random_burst(40);

        // fixed bubbles first, then a random mix
        drive_header(3, 3);
        insert_idle_cycle();
        drive_header(0, 0);
        insert_idle_cycle();
        insert_idle_cycle();
        drive_header(2, 3);
        send_gapped_traffic(40);

        wait_for_drain(20);

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
design/route_pkg.sv
design/dest_port_decoder.sv
design/next_router_addr_predictor.sv
design/xy_mesh_routing.sv
design/mesh_look_ahead_routing.sv
testbench/tb_mesh_look_ahead_routing.sv

//--- run.sh
#!/bin/sh
# build and run the look-ahead routing testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_mesh_look_ahead_routing \
    -f compile.f -Mdir obj_dir -o tb_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

# a fatal stop exits non-zero, the log line decides the result
./obj_dir/tb_sim > sim.log 2>&1

grep -qx "Finished with errors" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -qx "Finished with no errors" sim.log && { echo "PASS"; exit 0; }
echo "FAIL, no result line in sim.log" && exit 1
